/* src/jpeg_pkg.sv */
package jpeg_pkg;

    localparam int coeff_w = 11;     // Quantized coefficient, signed
    localparam int bits_w  = 12;     // Appended coefficient bits
    localparam int size_w  = 4;      // Size category
    localparam int code_w  = 16;     // Huffman code
    localparam int len_w   = 5;      // Huffman code length

    // Worst case for one lane: longest code plus an 11-bit DC difference
    localparam int lane_bits_max = code_w + coeff_w;

    // Table address as a byte, or the run/size pair it encodes
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] run;
            logic [3:0] size;
        } rs;
    } huff_symbol_t;

    localparam logic [7:0] sym_eob = 8'h00;
    localparam logic [7:0] sym_zrl = 8'hf0;

    // Bit 0 selects chroma, bit 1 selects AC
    typedef logic [1:0] tbl_sel_t;

    localparam tbl_sel_t tbl_dc_luma   = 2'b00;
    localparam tbl_sel_t tbl_dc_chroma = 2'b01;
    localparam tbl_sel_t tbl_ac_luma   = 2'b10;
    localparam tbl_sel_t tbl_ac_chroma = 2'b11;

endpackage

/* src/huff_tables.sv */
module huff_tables (
    input  logic                          clk,

    input  logic                          we,
    input  jpeg_pkg::tbl_sel_t            wsel,
    input  jpeg_pkg::huff_symbol_t        waddr,
    input  logic [jpeg_pkg::len_w-1:0]    wlen,
    input  logic [jpeg_pkg::code_w-1:0]   wcode,

    input  jpeg_pkg::huff_symbol_t        symbol [1:0],
    input  logic                          re [1:0],
    input  jpeg_pkg::tbl_sel_t            sel [1:0],
    output logic [jpeg_pkg::len_w-1:0]    len [1:0],
    output logic [jpeg_pkg::code_w-1:0]   code [1:0]
);
    import jpeg_pkg::*;

    localparam int entry_w = len_w + code_w;

    // DC luma, DC chroma, AC luma, AC chroma; each entry is {length, code}
    logic [entry_w-1:0] mem [4][256];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wsel][waddr.raw] <= {wlen, wcode};
        end
    end

    // Registered read lanes, output holds while re is low
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (re[i]) begin
                {len[i], code[i]} <= mem[sel[i]][symbol[i].raw];
            end
        end
    end

    // Loading is only legal while the encoder is idle
    a_no_rw: assert property (@(posedge clk) we |-> !(re[0] || re[1]));

endmodule

/* src/entropy.sv */
module entropy (
    input  logic                                  clk,
    input  logic                                  resetn,

    input  logic signed [jpeg_pkg::coeff_w-1:0]   q [1:0],
    input  logic                                  q_valid,
    output logic                                  q_hold,
    input  logic [4:0]                            q_cnt,
    input  logic                                  q_chroma,
    input  logic                                  q_sof,

    output jpeg_pkg::huff_symbol_t                ht_symbol [1:0],
    output logic                                  ht_re [1:0],
    output jpeg_pkg::tbl_sel_t                    ht_sel [1:0],
    input  logic [jpeg_pkg::len_w-1:0]            ht_len [1:0],
    input  logic [jpeg_pkg::code_w-1:0]           ht_code [1:0],

    output logic [jpeg_pkg::code_w-1:0]           ent_code [1:0],
    output logic [jpeg_pkg::len_w-1:0]            ent_code_len [1:0],
    output logic [jpeg_pkg::bits_w-1:0]           ent_bits [1:0],
    output logic [jpeg_pkg::size_w-1:0]           ent_bits_len [1:0],
    output logic                                  ent_valid [1:0],
    input  logic                                  ent_hold
);
    import jpeg_pkg::*;

    logic                       accept;
    logic                       is_dc;
    logic signed [coeff_w-1:0]  dc_pred;
    logic signed [coeff_w-1:0]  pred_eff;
    logic signed [bits_w-1:0]   dc_diff;
    logic [5:0]                 run_q;          // Zeros since last emitted symbol

    logic signed [bits_w-1:0]   lane_value [1:0];
    logic [size_w-1:0]          lane_size [1:0];
    logic [bits_w-1:0]          lane_bits [1:0];
    logic                       nz [1:0];
    logic                       lane_valid [1:0];
    logic [5:0]                 run [1:0];
    logic [5:0]                 run_next;
    logic                       eob;
    logic                       no_sym;
    logic [1:0]                 zrl_n;          // ZRLs owed ahead of this pair
    logic                       ins_b [1:0];
    logic                       ins_c;

    // Pipeline stages A and B, stage C is the ent outputs
    logic                       va [1:0];
    logic                       vb [1:0];
    logic [bits_w-1:0]          bits_a [1:0];
    logic [size_w-1:0]          blen_a [1:0];
    logic [code_w-1:0]          code_b [1:0];
    logic [len_w-1:0]           clen_b [1:0];
    logic [bits_w-1:0]          bits_b [1:0];
    logic [size_w-1:0]          blen_b [1:0];

    // Bit length of the magnitude
    function automatic logic [size_w-1:0] coeff_size(input logic signed [bits_w-1:0] v);
        logic [bits_w-1:0] mag;
        logic [size_w-1:0] size;
        mag  = v[bits_w-1] ? bits_w'(-v) : bits_w'(v);
        size = '0;
        for (int b = 0; b < bits_w; b++) begin
            if (mag[b]) begin
                size = size_w'(b + 1);
            end
        end
        return size;
    endfunction

    assign accept   = q_valid && !ent_hold;
    assign q_hold   = ent_hold;
    assign is_dc    = (q_cnt == 5'd0);
    assign pred_eff = q_sof ? '0 : dc_pred;     // New scan predicts from zero
    assign dc_diff  = bits_w'(q[0]) - bits_w'(pred_eff);

    always_comb begin
        lane_value[0] = is_dc ? dc_diff : bits_w'(q[0]);
        lane_value[1] = bits_w'(q[1]);
        for (int i = 0; i < 2; i++) begin
            lane_size[i] = coeff_size(lane_value[i]);
            // Negative values send the ones' complement of the magnitude
            lane_bits[i] = (lane_value[i] < 0 ? lane_value[i] - 1 : lane_value[i])
                         & ~({bits_w{1'b1}} << lane_size[i]);
        end
    end

    assign nz[0]         = (q[0] != '0);
    assign nz[1]         = (q[1] != '0);
    assign eob           = (q_cnt == 5'd31) && !nz[1];
    assign lane_valid[0] = is_dc || nz[0];
    assign lane_valid[1] = nz[1] || eob;
    assign no_sym        = !lane_valid[0] && !lane_valid[1];

    assign run[0]   = run_q;
    assign run[1]   = lane_valid[0] ? 6'd0 : run_q + 6'd1;
    assign run_next = lane_valid[1] ? 6'd0 : run[1] + 6'd1;

    always_comb begin
        if (nz[0] && !is_dc) begin
            zrl_n = run[0][5:4];
        end else if (nz[1]) begin
            zrl_n = run[1][5:4];
        end else begin
            zrl_n = 2'd0;
        end
    end

    // Slots freed by the zero run: B lane 1, then B lane 0, then C lane 1
    assign ins_b[1] = accept && (zrl_n != 2'd0);
    assign ins_b[0] = accept && zrl_n[1];
    assign ins_c    = accept && (&zrl_n);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (!lane_valid[i]) begin
                ht_symbol[i].raw = sym_zrl;         // Prefetch ZRL while the run grows
            end else if (i == 1 && eob) begin
                ht_symbol[i].raw = sym_eob;
            end else begin
                ht_symbol[i].rs.run  = (i == 0 && is_dc) ? 4'd0 : run[i][3:0];
                ht_symbol[i].rs.size = lane_size[i];
            end
            if (i == 0 && is_dc) begin
                ht_sel[i] = q_chroma ? tbl_dc_chroma : tbl_dc_luma;
            end else begin
                ht_sel[i] = q_chroma ? tbl_ac_chroma : tbl_ac_luma;
            end
            ht_re[i] = accept && (lane_valid[i] || no_sym);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dc_pred <= '0;
            run_q   <= '0;
        end else if (accept) begin
            run_q <= run_next;
            if (is_dc) begin
                dc_pred <= q[0];
            end else if (q_sof) begin
                dc_pred <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 2; i++) begin
                va[i]        <= 1'b0;
                vb[i]        <= 1'b0;
                ent_valid[i] <= 1'b0;
            end
        end else if (!ent_hold) begin
            for (int i = 0; i < 2; i++) begin
                va[i]        <= accept && lane_valid[i];
                vb[i]        <= va[i] || ins_b[i];
                ent_valid[i] <= vb[i] || (i == 1 && ins_c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ent_hold) begin
            for (int i = 0; i < 2; i++) begin
                if (accept && lane_valid[i]) begin
                    bits_a[i] <= lane_bits[i];
                    blen_a[i] <= lane_size[i];
                end
                // Table output is either stage A's code or the prefetched ZRL
                code_b[i] <= ht_code[i];
                clen_b[i] <= ht_len[i];
                bits_b[i] <= bits_a[i];
                blen_b[i] <= ins_b[i] ? '0 : blen_a[i];

                if (i == 1 && ins_c) begin
                    ent_code[i]     <= ht_code[i];
                    ent_code_len[i] <= ht_len[i];
                    ent_bits_len[i] <= '0;
                end else begin
                    ent_code[i]     <= code_b[i];
                    ent_code_len[i] <= clen_b[i];
                    ent_bits_len[i] <= blen_b[i];
                end
                ent_bits[i] <= bits_b[i];
            end
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_chk
        a_code_len: assert property (@(posedge clk) disable iff (!resetn)
            ent_valid[i] |-> ent_code_len[i] <= len_w'(code_w));
        a_held: assert property (@(posedge clk) disable iff (!resetn)
            ent_valid[i] && ent_hold |=> ent_valid[i] && $stable(ent_code[i])
                                         && $stable(ent_bits_len[i]));
    end

endmodule

/* src/bit_packer.sv */
module bit_packer #(
    parameter int acc_w = 64
) (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic [jpeg_pkg::code_w-1:0]   ent_code [1:0],
    input  logic [jpeg_pkg::len_w-1:0]    ent_code_len [1:0],
    input  logic [jpeg_pkg::bits_w-1:0]   ent_bits [1:0],
    input  logic [jpeg_pkg::size_w-1:0]   ent_bits_len [1:0],
    input  logic                          ent_valid [1:0],
    output logic                          ent_hold,

    output logic [7:0]                    byte_data,
    output logic                          byte_valid,
    input  logic                          byte_hold,
    input  logic                          flush
);
    import jpeg_pkg::*;

    localparam int fill_w    = $clog2(acc_w + 1);
    localparam int cycle_max = 2 * lane_bits_max;   // Two lanes of code plus bits

    logic [acc_w-1:0]   acc;        // MSB-aligned, valid bits on top
    logic [acc_w-1:0]   acc_next;
    logic [fill_w-1:0]  fill;
    logic [fill_w-1:0]  fill_next;
    logic               stuff_pend; // 0x00 owed after an 0xFF
    logic               out_free;
    logic               pop;
    logic [7:0]         top_byte;

    assign top_byte = acc[acc_w-1 -: 8];
    assign out_free = !byte_valid || !byte_hold;
    assign pop      = out_free && !stuff_pend && (fill >= fill_w'(8));
    assign ent_hold = stuff_pend || (fill > fill_w'(acc_w - cycle_max));

    always_comb begin
        logic [acc_w-1:0] a;
        int f;
        int n;
        a = pop ? acc << 8 : acc;
        f = pop ? int'(fill) - 8 : int'(fill);
        n = 0;
        if (!ent_hold) begin
            // Lane 0 before lane 1, code before bits
            for (int i = 0; i < 2; i++) begin
                if (ent_valid[i]) begin
                    n = int'(ent_code_len[i]);
                    a = a | (acc_w'(ent_code[i]) << (acc_w - f - n));
                    f = f + n;
                    n = int'(ent_bits_len[i]);
                    // Only the low n bits belong to the field
                    a = a | ((acc_w'(ent_bits[i]) & ~({acc_w{1'b1}} << n))
                             << (acc_w - f - n));
                    f = f + n;
                end
            end
        end
        if (flush) begin
            n = (8 - (f % 8)) % 8;  // Ones up to the byte boundary
            a = a | (~({acc_w{1'b1}} << n) << (acc_w - f - n));
            f = f + n;
        end
        acc_next  = a;
        fill_next = fill_w'(f);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc        <= '0;
            fill       <= '0;
            stuff_pend <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            acc  <= acc_next;
            fill <= fill_next;
            if (out_free) begin
                if (stuff_pend) begin
                    byte_valid <= 1'b1;
                    stuff_pend <= 1'b0;
                end else if (pop) begin
                    byte_valid <= 1'b1;
                    stuff_pend <= (top_byte == 8'hff);
                end else begin
                    byte_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            byte_data <= stuff_pend ? 8'h00 : top_byte;
        end
    end

    a_fill: assert property (@(posedge clk) disable iff (!resetn)
        fill <= fill_w'(acc_w));

endmodule

/* src/jpeg_entropy_top.sv */
module jpeg_entropy_top #(
    parameter int acc_w = 64
) (
    input  logic                                  clk,
    input  logic                                  resetn,

    input  logic                                  tbl_we,
    input  jpeg_pkg::tbl_sel_t                    tbl_sel,
    input  jpeg_pkg::huff_symbol_t                tbl_addr,
    input  logic [jpeg_pkg::len_w-1:0]            tbl_len,
    input  logic [jpeg_pkg::code_w-1:0]           tbl_code,

    input  logic signed [jpeg_pkg::coeff_w-1:0]   q [1:0],
    input  logic                                  q_valid,
    output logic                                  q_hold,
    input  logic [4:0]                            q_cnt,
    input  logic                                  q_chroma,
    input  logic                                  q_sof,

    output logic [7:0]                            byte_data,
    output logic                                  byte_valid,
    input  logic                                  byte_hold,
    input  logic                                  flush
);
    import jpeg_pkg::*;

    // Table read lanes
    huff_symbol_t       ht_symbol [1:0];
    logic               ht_re [1:0];
    tbl_sel_t           ht_sel [1:0];
    logic [len_w-1:0]   ht_len [1:0];
    logic [code_w-1:0]  ht_code [1:0];

    // Entropy to packer
    logic [code_w-1:0]  ent_code [1:0];
    logic [len_w-1:0]   ent_code_len [1:0];
    logic [bits_w-1:0]  ent_bits [1:0];
    logic [size_w-1:0]  ent_bits_len [1:0];
    logic               ent_valid [1:0];
    logic               ent_hold;

    huff_tables u_tables (
        .clk     (clk),
        .we      (tbl_we),
        .wsel    (tbl_sel),
        .waddr   (tbl_addr),
        .wlen    (tbl_len),
        .wcode   (tbl_code),
        .symbol  (ht_symbol),
        .re      (ht_re),
        .sel     (ht_sel),
        .len     (ht_len),
        .code    (ht_code)
    );

    entropy u_entropy (
        .clk          (clk),
        .resetn       (resetn),
        .q            (q),
        .q_valid      (q_valid),
        .q_hold       (q_hold),
        .q_cnt        (q_cnt),
        .q_chroma     (q_chroma),
        .q_sof        (q_sof),
        .ht_symbol    (ht_symbol),
        .ht_re        (ht_re),
        .ht_sel       (ht_sel),
        .ht_len       (ht_len),
        .ht_code      (ht_code),
        .ent_code     (ent_code),
        .ent_code_len (ent_code_len),
        .ent_bits     (ent_bits),
        .ent_bits_len (ent_bits_len),
        .ent_valid    (ent_valid),
        .ent_hold     (ent_hold)
    );

    bit_packer #(
        .acc_w (acc_w)
    ) u_packer (
        .clk          (clk),
        .resetn       (resetn),
        .ent_code     (ent_code),
        .ent_code_len (ent_code_len),
        .ent_bits     (ent_bits),
        .ent_bits_len (ent_bits_len),
        .ent_valid    (ent_valid),
        .ent_hold     (ent_hold),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .byte_hold    (byte_hold),
        .flush        (flush)
    );

endmodule

/* sim/jpeg_ref_model.svh */
// Expected stream model, encodes blk_coef[] into exp_q

localparam int ac_len = 9;

int ref_acc;    // Pending bits, right-aligned
int ref_fill;

function automatic int dc_len_of(int s);
    return 3 + s;
endfunction

// s ones, a zero, then two bits that tell luma from chroma
function automatic int dc_code_of(bit chroma, int s);
    return (((1 << s) - 1) << 3) | (chroma ? 3 : 0);
endfunction

// A leading one, then the symbol; chroma inverts the symbol
function automatic int ac_code_of(bit chroma, int sym);
    return 256 | (chroma ? (sym ^ 255) : sym);
endfunction

function automatic int size_of(int v);
    int mag;
    int s;
    mag = (v < 0) ? -v : v;
    s = 0;
    while (mag > 0) begin
        s++;
        mag = mag >> 1;
    end
    return s;
endfunction

function automatic int bits_of(int v, int s);
    return (v < 0) ? v + (1 << s) - 1 : v;   // Ones' complement for negatives
endfunction

// MSB-first append with 0x00 after each 0xFF
function automatic void put_bits(int val, int n);
    int b;
    ref_acc  = (ref_acc << n) | (val & ((1 << n) - 1));
    ref_fill = ref_fill + n;
    while (ref_fill >= 8) begin
        b = (ref_acc >> (ref_fill - 8)) & 255;
        exp_q.push_back(8'(b));
        if (b == 255) exp_q.push_back(8'h00);
        ref_fill = ref_fill - 8;
    end
    ref_acc = ref_acc & ((1 << ref_fill) - 1);
endfunction

function automatic void encode_blocks();
    int pred;
    int run;
    int v;
    int s;
    bit c;
    exp_q.delete();
    ref_acc  = 0;
    ref_fill = 0;
    pred     = 0;
    for (int b = 0; b < n_blocks; b++) begin
        c = blk_chroma[b];
        if (blk_sof[b]) pred = 0;
        v    = blk_coef[b * 64] - pred;
        pred = blk_coef[b * 64];
        s    = size_of(v);
        put_bits(dc_code_of(c, s), dc_len_of(s));
        put_bits(bits_of(v, s), s);
        run = 0;
        for (int k = 1; k < 64; k++) begin
            v = blk_coef[b * 64 + k];
            if (v == 0) begin
                run++;
            end else begin
                while (run >= 16) begin
                    put_bits(ac_code_of(c, 8'hf0), ac_len);    // ZRL
                    run = run - 16;
                end
                s = size_of(v);
                put_bits(ac_code_of(c, run * 16 + s), ac_len);
                put_bits(bits_of(v, s), s);
                run = 0;
            end
        end
        if (run > 0) put_bits(ac_code_of(c, 8'h00), ac_len);  // EOB
    end
    pre_flush_n = exp_q.size();
    if (ref_fill > 0) put_bits((1 << (8 - ref_fill)) - 1, 8 - ref_fill);
endfunction

/* sim/tb_jpeg_entropy.sv */
module tb_jpeg_entropy;
    timeunit 1ns;
    timeprecision 100ps;
    import jpeg_pkg::*;

    localparam int max_blocks = 24;
    localparam int wait_limit = 20000;

    logic                       clk;
    logic                       resetn;
    logic                       tbl_we;
    tbl_sel_t                   tbl_sel;
    huff_symbol_t               tbl_addr;
    logic [len_w-1:0]           tbl_len;
    logic [code_w-1:0]          tbl_code;
    logic signed [coeff_w-1:0]  q [1:0];
    logic                       q_valid;
    logic                       q_hold;
    logic [4:0]                 q_cnt;
    logic                       q_chroma;
    logic                       q_sof;
    logic [7:0]                 byte_data;
    logic                       byte_valid;
    logic                       byte_hold;
    logic                       flush;

    int         blk_coef [max_blocks * 64];    // Zigzag order, 64 per block
    bit         blk_chroma [max_blocks];
    bit         blk_sof [max_blocks];
    int         n_blocks;
    logic [7:0] exp_q [$];
    logic [7:0] got_q [$];
    int         pre_flush_n;                    // Bytes due before the flush pulse
    integer     seed = 32'h93c0_9bed;
    bit         hold_en;
    bit         gaps_en;
    int         test_errs;
    int         tests_run;
    int         tests_failed;
    int         total_errs;

    `include "jpeg_ref_model.svh"

    jpeg_entropy_top #(
        .acc_w (64)
    ) dut (
        .clk        (clk),
        .resetn     (resetn),
        .tbl_we     (tbl_we),
        .tbl_sel    (tbl_sel),
        .tbl_addr   (tbl_addr),
        .tbl_len    (tbl_len),
        .tbl_code   (tbl_code),
        .q          (q),
        .q_valid    (q_valid),
        .q_hold     (q_hold),
        .q_cnt      (q_cnt),
        .q_chroma   (q_chroma),
        .q_sof      (q_sof),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_hold  (byte_hold),
        .flush      (flush)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic int rand_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Output stall for the back-pressure test
    always @(posedge clk) begin
        byte_hold <= #1 hold_en && (rand_range(0, 2) == 0);
    end

    // Record each byte half a cycle before its transfer edge
    always @(negedge clk) begin
        if (resetn && byte_valid && !byte_hold) begin
            got_q.push_back(byte_data);
        end
    end

    task automatic abort_run(string what);
        $display("Timeout: %s", what);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic check_byte(string name, int idx, logic [7:0] exp, logic [7:0] act);
        if (act !== exp) begin
            $display("** Error %s byte %0d: expected %02h, actual %02h", name, idx, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("** Error %s byte count: expected %0d, actual %0d", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_block(bit chroma, bit sof, int dc);
        for (int k = 0; k < 64; k++) begin
            blk_coef[n_blocks * 64 + k] = 0;
        end
        blk_coef[n_blocks * 64] = dc;
        blk_chroma[n_blocks]    = chroma;
        blk_sof[n_blocks]       = sof;
        n_blocks++;
    endtask

    task automatic set_coef(int pos, int val);
        blk_coef[(n_blocks - 1) * 64 + pos] = val;
    endtask

    task automatic load_tables();
        int n;
        for (int t = 0; t < 4; t++) begin
            n = t[1] ? 256 : 12;    // DC sizes run 0 to 11
            for (int a = 0; a < n; a++) begin
                tbl_we       = 1'b1;
                tbl_sel      = tbl_sel_t'(t);
                tbl_addr.raw = 8'(a);
                if (t[1]) begin
                    tbl_len  = len_w'(ac_len);
                    tbl_code = code_w'(ac_code_of(t[0], a));
                end else begin
                    tbl_len  = len_w'(dc_len_of(a));
                    tbl_code = code_w'(dc_code_of(t[0], a));
                end
                @(posedge clk);
                #1;
            end
        end
        tbl_we = 1'b0;
    endtask

    task automatic send_blocks();
        int  waited;
        bit  taken;
        for (int b = 0; b < n_blocks; b++) begin
            for (int k = 0; k < 32; k++) begin
                if (gaps_en) begin
                    q_valid = 1'b0;
                    repeat (rand_range(0, 2)) begin
                        @(posedge clk);
                        #1;
                    end
                end
                q[0]     = coeff_w'(blk_coef[b * 64 + 2 * k]);
                q[1]     = coeff_w'(blk_coef[b * 64 + 2 * k + 1]);
                q_cnt    = 5'(k);
                q_chroma = blk_chroma[b];
                q_sof    = blk_sof[b] && (k == 0);
                q_valid  = 1'b1;
                taken    = 1'b0;
                waited   = 0;
                while (!taken) begin
                    taken = !q_hold;    // q_hold only moves at the clock edge
                    @(posedge clk);
                    #1;
                    waited++;
                    if (!taken && waited > wait_limit) abort_run("coefficient pair not accepted");
                end
            end
        end
        q_valid = 1'b0;
        q_sof   = 1'b0;
    endtask

    // Last pair needs three pipeline edges plus one packer edge
    task automatic wait_drain();
        int unheld;
        int waited;
        unheld = 0;
        waited = 0;
        while (unheld < 4) begin
            if (!q_hold) unheld++;
            @(posedge clk);
            #1;
            waited++;
            if (unheld < 4 && waited > wait_limit) abort_run("entropy pipeline did not drain");
        end
    endtask

    task automatic wait_bytes(int n, string what);
        int waited;
        waited = 0;
        while (got_q.size() < n) begin
            @(posedge clk);
            #1;
            waited++;
            if (got_q.size() < n && waited > wait_limit) abort_run(what);
        end
    endtask

    task automatic run_test(string name);
        got_q.delete();
        encode_blocks();
        test_errs = 0;
        send_blocks();
        wait_drain();
        wait_bytes(pre_flush_n, "bytes before flush never arrived");
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        wait_bytes(exp_q.size(), "padded final byte never arrived");
        repeat (16) begin
            @(posedge clk);     // Room for any surplus byte
            #1;
        end
        check_count(name, exp_q.size(), got_q.size());
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_byte(name, i, exp_q[i], got_q[i]);
        end
        tests_run++;
        total_errs = total_errs + test_errs;
        if (test_errs != 0) tests_failed++;
        $display("test %-14s %0d bytes, %0d errors, %s", name, got_q.size(), test_errs,
                 (test_errs == 0) ? "pass" : "fail");
        n_blocks = 0;
    endtask

    initial begin
        int v;
        resetn       = 1'b0;
        tbl_we       = 1'b0;
        tbl_sel      = tbl_dc_luma;
        tbl_addr.raw = 8'h00;
        tbl_len      = '0;
        tbl_code     = '0;
        q[0]         = '0;
        q[1]         = '0;
        q_valid      = 1'b0;
        q_cnt        = '0;
        q_chroma     = 1'b0;
        q_sof        = 1'b0;
        byte_hold    = 1'b0;
        flush        = 1'b0;
        hold_en      = 1'b0;
        gaps_en      = 1'b0;
        n_blocks     = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_errs   = 0;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        load_tables();

        // DC only, prediction from zero at start of scan
        start_block(0, 1, 37);
        start_block(0, 0, -12);
        start_block(0, 0, -200);
        run_test("dc_prediction");

        start_block(0, 1, 100);
        set_coef(1, 5);
        set_coef(4, -3);
        set_coef(9, 1);
        set_coef(20, -1);
        set_coef(35, 12);
        set_coef(50, -20);
        set_coef(63, 7);         // No EOB
        start_block(0, 0, 90);
        set_coef(2, -2);
        set_coef(7, 3);
        set_coef(16, -8);
        set_coef(30, 1);
        start_block(1, 0, -90);
        set_coef(15, 4);
        set_coef(30, -4);
        set_coef(45, 2);
        set_coef(60, -2);
        set_coef(62, 1);
        set_coef(63, -1);
        start_block(0, 0, 0);
        run_test("run_length");

        // Runs of 16 to 62 zeros, even and odd positions
        start_block(0, 1, 10);
        set_coef(1, 3);
        set_coef(18, -4);
        set_coef(36, 5);
        set_coef(53, -6);
        start_block(0, 0, 10);
        set_coef(33, 7);
        set_coef(63, -2);
        start_block(0, 0, -10);
        set_coef(48, 9);
        start_block(0, 0, 0);
        set_coef(49, -9);
        set_coef(63, 1);
        start_block(1, 0, 3);
        set_coef(1, 2);
        set_coef(50, -3);
        start_block(0, 0, 3);
        set_coef(1, 1);
        set_coef(34, -1);
        set_coef(51, 2);
        set_coef(63, 3);
        start_block(0, 0, 3);
        set_coef(1, -1);
        set_coef(19, 2);         // Run of 17 in lane 1
        start_block(1, 0, 3);
        set_coef(1, 1);
        set_coef(49, -7);        // Run of 47 in lane 1
        start_block(0, 0, 3);
        set_coef(63, -5);
        run_test("zrl_insertion");

        // Chroma codes are mostly ones, so 0xFF bytes are frequent
        start_block(1, 1, 40);
        for (int k = 1; k < 20; k++) begin
            set_coef(k, 1);
        end
        start_block(1, 0, 40);
        start_block(0, 0, 40);
        set_coef(5, -1);
        start_block(1, 0, 41);
        set_coef(63, 1);
        run_test("chroma_stuffing");

        gaps_en = 1'b1;
        hold_en = 1'b1;
        for (int b = 0; b < 20; b++) begin
            start_block(rand_range(0, 1) == 1, b == 0, rand_range(-300, 300));
            for (int k = 1; k < 64; k++) begin
                if (rand_range(0, 3) == 0) begin
                    v = rand_range(-60, 59);
                    set_coef(k, (v >= 0) ? v + 1 : v);
                end
            end
        end
        run_test("back_pressure");
        gaps_en = 1'b0;
        hold_en = 1'b0;

        // 18 bits, so the last byte carries six padding ones
        start_block(0, 1, 5);
        run_test("flush_padding");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* jpeg_entropy.f */
+incdir+sim
src/jpeg_pkg.sv
src/huff_tables.sv
src/entropy.sv
src/bit_packer.sv
src/jpeg_entropy_top.sv
sim/tb_jpeg_entropy.sv
